// File: hw/residu_defs.svh
`ifndef RESIDU_DEFS_SVH
`define RESIDU_DEFS_SVH

////////////////////////////////////////
// Sizes fixed by the codec
////////////////////////////////////////

// Sample memory address width, 256 words
`define ADDR_W 8

// Filter order, taps run from a[0] to a[ORDER]
`define ORDER 10

// Output samples per frame
`define FRAME_LEN 40

////////////////////////////////////////
// Memory map
////////////////////////////////////////

// Coefficient a[j] at COEF_BASE + j
`define COEF_BASE 0

// Input x[n] at X_BASE + ORDER + n, n from -ORDER to FRAME_LEN-1
`define X_BASE 16

// Output y[n] at Y_BASE + n
`define Y_BASE 128

`endif

// File: hw/residuPkg.sv
`include "residu_defs.svh"

package residuPkg;

	////////////////////////////////////////
	// Data types shared by the datapath
	////////////////////////////////////////

	// One memory word, either a Q15 sample or a coefficient
	typedef logic signed [15:0] sample_t;

	// Accumulator for the saturating multiply-accumulate
	typedef logic signed [31:0] acc_t;

	// Sample memory address
	typedef logic [`ADDR_W-1:0] addr_t;

endpackage

// File: hw/sampleMem.sv
`timescale 1ns/1ns

`include "residu_defs.svh"

module sampleMem
(
	input logic clk,
	input logic we,
	input residuPkg::addr_t addr,
	input residuPkg::sample_t wdata,
	output residuPkg::sample_t rdata
);

	import residuPkg::*;

	// Whole address space backed by storage
	sample_t mem [0:(1 << `ADDR_W) - 1];

	// Read returns the old word when a write hits the same address
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

// File: hw/memArbiter.sv
`timescale 1ns/1ns

module memArbiter
(
	input logic clk,
	input logic rst,
	input logic memReqHost,
	input logic memReqEng,
	output logic gntHost,
	output logic gntEng,
	input residuPkg::addr_t hostAddr,
	input residuPkg::addr_t engAddr,
	input logic hostWe,
	input logic engWe,
	input residuPkg::sample_t hostWdata,
	input residuPkg::sample_t engWdata,
	output residuPkg::addr_t memAddr,
	output logic memWe,
	output residuPkg::sample_t memWdata
);

	////////////////////////////////////////
	// Grant state
	////////////////////////////////////////

	// A held grant only follows its own request
	// New grants go to the host first when the memory is free
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			gntHost <= 1'b0;
			gntEng <= 1'b0;
		end
		else if (gntHost)
		begin
			gntHost <= memReqHost;
		end
		else if (gntEng)
		begin
			gntEng <= memReqEng;
		end
		else if (memReqHost)
		begin
			gntHost <= 1'b1;
		end
		else if (memReqEng)
		begin
			gntEng <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Shared memory bus
	////////////////////////////////////////

	assign memAddr = gntHost ? hostAddr : engAddr;
	assign memWdata = gntHost ? hostWdata : engWdata;

	// No write reaches the memory without a grant
	assign memWe = (gntHost & hostWe) | (gntEng & engWe);

endmodule

// File: hw/satMacUnit.sv
`timescale 1ns/1ns

module satMacUnit
(
	input logic clk,
	input logic rst,
	input logic clear,
	input logic en,
	input residuPkg::sample_t coef,
	input residuPkg::sample_t sample,
	output residuPkg::acc_t acc,
	output residuPkg::sample_t result
);

	import residuPkg::*;

	localparam sample_t SAMPLE_MIN = 16'sh8000;
	localparam acc_t ACC_MAX = 32'sh7fff_ffff;
	localparam acc_t ACC_MIN = 32'sh8000_0000;

	acc_t prodRaw;
	acc_t product;
	logic signed [32:0] sum;
	acc_t sumSat;
	logic signed [34:0] shifted;
	acc_t shiftSat;
	logic signed [32:0] rounded;
	acc_t roundSat;

	////////////////////////////////////////
	// Fractional multiply
	////////////////////////////////////////

	assign prodRaw = coef * sample;

	// Only -1 times -1 overflows after doubling
	assign product = (coef == SAMPLE_MIN && sample == SAMPLE_MIN) ? ACC_MAX : (prodRaw <<< 1);

	// Saturating add into the accumulator
	assign sum = {acc[31], acc} + {product[31], product};
	assign sumSat = (sum[32] != sum[31]) ? (sum[32] ? ACC_MIN : ACC_MAX) : sum[31:0];

	always_ff @(posedge clk)
	begin
		if (rst || clear)
		begin
			acc <= '0;
		end
		else if (en)
		begin
			acc <= sumSat;
		end
	end

	////////////////////////////////////////
	// Output stage
	////////////////////////////////////////

	// Shift left by three, saturate when the top four bits disagree
	assign shifted = {{3{acc[31]}}, acc} <<< 3;
	assign shiftSat = (shifted[34:31] == 4'b0000 || shifted[34:31] == 4'b1111) ?
		shifted[31:0] : (shifted[34] ? ACC_MIN : ACC_MAX);

	// Round to nearest, only positive overflow is possible
	assign rounded = {shiftSat[31], shiftSat} + 33'sd32768;
	assign roundSat = (rounded[32] != rounded[31]) ? ACC_MAX : rounded[31:0];

	assign result = roundSat[31:16];

endmodule

// File: hw/residuEngine.sv
`timescale 1ns/1ns

`include "residu_defs.svh"

module residuEngine
(
	input logic clk,
	input logic rst,
	input logic startReq,
	output logic startAck,
	output logic memReqEng,
	input logic gntEng,
	output residuPkg::addr_t engAddr,
	output logic engWe,
	output residuPkg::sample_t engWdata,
	input residuPkg::sample_t memRdata,
	output logic macClear,
	output logic macEn,
	output residuPkg::sample_t macCoef,
	output residuPkg::sample_t macSample,
	input residuPkg::sample_t macResult
);

	import residuPkg::*;

	typedef enum logic [2:0]
	{
		stIdle,
		stClaim,
		stCoef,
		stSamp,
		stMac,
		stWrite,
		stDone
	} engState_t;

	engState_t state;
	logic [5:0] outIdx;
	logic [3:0] tapIdx;
	sample_t coefReg;

	logic lastTap;
	logic lastOut;

	assign lastTap = (tapIdx == 4'(`ORDER));
	assign lastOut = (outIdx == 6'(`FRAME_LEN - 1));

	////////////////////////////////////////
	// Frame sequencer
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= stIdle;
			outIdx <= '0;
			tapIdx <= '0;
		end
		else
		begin
			case (state)
				stIdle:
					if (startReq)
					begin
						outIdx <= '0;
						tapIdx <= '0;
						state <= stClaim;
					end
				stClaim:
					if (gntEng)
					begin
						state <= stCoef;
					end
				stCoef:
					state <= stSamp;
				stSamp:
					state <= stMac;
				stMac:
					if (lastTap)
					begin
						tapIdx <= '0;
						state <= stWrite;
					end
					else
					begin
						tapIdx <= tapIdx + 4'd1;
						state <= stCoef;
					end
				stWrite:
					if (lastOut)
					begin
						state <= stDone;
					end
					else
					begin
						outIdx <= outIdx + 6'd1;
						state <= stCoef;
					end
				// Hold the ack until the host lets go of start
				stDone:
					if (!startReq)
					begin
						state <= stIdle;
					end
				default:
					state <= stIdle;
			endcase
		end
	end

	// Coefficient arrives one cycle after its address
	always_ff @(posedge clk)
	begin
		if (state == stSamp)
		begin
			coefReg <= memRdata;
		end
	end

	////////////////////////////////////////
	// Memory and MAC controls
	////////////////////////////////////////

	// Claim held for the whole frame
	assign memReqEng = (state != stIdle) && (state != stDone);
	assign startAck = (state == stDone);

	always_comb
	begin
		engAddr = '0;
		engWe = 1'b0;
		case (state)
			stCoef:
				engAddr = addr_t'(`COEF_BASE + tapIdx);
			// x[n-j] sits ORDER words above X_BASE
			stSamp:
				engAddr = addr_t'(`X_BASE + `ORDER + outIdx - tapIdx);
			stWrite:
			begin
				engAddr = addr_t'(`Y_BASE + outIdx);
				engWe = 1'b1;
			end
			default:
				engAddr = '0;
		endcase
	end

	assign engWdata = macResult;

	// Accumulator cleared at frame start and after each stored output
	assign macClear = (state == stWrite) || (state == stIdle && startReq);
	assign macEn = (state == stMac);
	assign macCoef = coefReg;
	assign macSample = memRdata;

endmodule

// File: hw/hostPort.sv
`timescale 1ns/1ns

module hostPort
(
	input logic clk,
	input logic rst,
	input logic hostReq,
	input logic hostWe,
	input residuPkg::addr_t hostAddr,
	input residuPkg::sample_t hostWdata,
	output logic hostAck,
	output residuPkg::sample_t hostRdata,
	output logic memReqHost,
	input logic gntHost,
	output residuPkg::addr_t portAddr,
	output logic portWe,
	output residuPkg::sample_t portWdata,
	input residuPkg::sample_t memRdata
);

	typedef enum logic [2:0]
	{
		stIdle,
		stClaim,
		stAccess,
		stCapture,
		stAck
	} portState_t;

	portState_t state;

	////////////////////////////////////////
	// Access sequencer
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= stIdle;
		end
		else
		begin
			case (state)
				stIdle:
					if (hostReq)
					begin
						state <= stClaim;
					end
				stClaim:
					if (gntHost)
					begin
						state <= stAccess;
					end
				// Writes are done here, reads need one more cycle
				stAccess:
					state <= hostWe ? stAck : stCapture;
				stCapture:
					state <= stAck;
				stAck:
					if (!hostReq)
					begin
						state <= stIdle;
					end
				default:
					state <= stIdle;
			endcase
		end
	end

	// Read word valid one cycle after the access
	always_ff @(posedge clk)
	begin
		if (state == stCapture)
		begin
			hostRdata <= memRdata;
		end
	end

	// Claim dropped once the access is on the bus
	assign memReqHost = (state == stClaim) || (state == stAccess);
	assign hostAck = (state == stAck);

	// Host keeps address and data stable for the whole handshake
	assign portAddr = hostAddr;
	assign portWdata = hostWdata;
	assign portWe = (state == stAccess) && hostWe;

endmodule

// File: hw/residuTop.sv
`timescale 1ns/1ns

module residuTop
(
	input logic clk,
	input logic rst,
	input logic hostReq,
	input logic hostWe,
	input residuPkg::addr_t hostAddr,
	input residuPkg::sample_t hostWdata,
	output logic hostAck,
	output residuPkg::sample_t hostRdata,
	input logic startReq,
	output logic startAck
);

	import residuPkg::*;

	// Arbitration
	logic memReqHost;
	logic memReqEng;
	logic gntHost;
	logic gntEng;

	// Peer buses
	addr_t portAddr;
	logic portWe;
	sample_t portWdata;
	addr_t engAddr;
	logic engWe;
	sample_t engWdata;

	// Shared memory bus
	addr_t memAddr;
	logic memWe;
	sample_t memWdata;
	sample_t memRdata;

	// MAC controls
	logic macClear;
	logic macEn;
	sample_t macCoef;
	sample_t macSample;
	sample_t macResult;

	sampleMem i_sampleMem
	(
		.clk(clk),
		.we(memWe),
		.addr(memAddr),
		.wdata(memWdata),
		.rdata(memRdata)
	);

	memArbiter i_memArbiter
	(
		.clk(clk),
		.rst(rst),
		.memReqHost(memReqHost),
		.memReqEng(memReqEng),
		.gntHost(gntHost),
		.gntEng(gntEng),
		.hostAddr(portAddr),
		.engAddr(engAddr),
		.hostWe(portWe),
		.engWe(engWe),
		.hostWdata(portWdata),
		.engWdata(engWdata),
		.memAddr(memAddr),
		.memWe(memWe),
		.memWdata(memWdata)
	);

	hostPort i_hostPort
	(
		.clk(clk),
		.rst(rst),
		.hostReq(hostReq),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostWdata(hostWdata),
		.hostAck(hostAck),
		.hostRdata(hostRdata),
		.memReqHost(memReqHost),
		.gntHost(gntHost),
		.portAddr(portAddr),
		.portWe(portWe),
		.portWdata(portWdata),
		.memRdata(memRdata)
	);

	residuEngine i_residuEngine
	(
		.clk(clk),
		.rst(rst),
		.startReq(startReq),
		.startAck(startAck),
		.memReqEng(memReqEng),
		.gntEng(gntEng),
		.engAddr(engAddr),
		.engWe(engWe),
		.engWdata(engWdata),
		.memRdata(memRdata),
		.macClear(macClear),
		.macEn(macEn),
		.macCoef(macCoef),
		.macSample(macSample),
		.macResult(macResult)
	);

	// Only the rounded result feeds the engine
	satMacUnit i_satMacUnit
	(
		.clk(clk),
		.rst(rst),
		.clear(macClear),
		.en(macEn),
		.coef(macCoef),
		.sample(macSample),
		.acc(),
		.result(macResult)
	);

endmodule

// File: bench/residu_sva.sv
`timescale 1ns/1ns

module residuSva
(
	input logic clk,
	input logic rst,
	input logic hostReq,
	input logic hostAck,
	input logic startReq,
	input logic startAck,
	input logic gntHost,
	input logic gntEng,
	input logic portWe,
	input logic engWe
);

	////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////

	grantsExclusive: assert property (@(posedge clk) disable iff (rst) !(gntHost && gntEng))
		else $error("Host and engine grants are high together");

	// Each peer writes only while it holds the memory
	hostWriteGranted: assert property (@(posedge clk) disable iff (rst)
		portWe |-> gntHost)
		else $error("Host port wrote to memory without a grant");

	engWriteGranted: assert property (@(posedge clk) disable iff (rst)
		engWe |-> gntEng)
		else $error("Engine wrote to memory without a grant");

	////////////////////////////////////////
	// Four-phase handshakes
	////////////////////////////////////////

	startAckRise: assert property (@(posedge clk) disable iff (rst)
		$rose(startAck) |-> $past(startReq))
		else $error("startAck rose while startReq was low");

	hostAckFall: assert property (@(posedge clk) disable iff (rst)
		$fell(hostAck) |-> !$past(hostReq))
		else $error("hostAck fell while hostReq was still high");

endmodule

bind residuTop residuSva i_residuSva
(
	.clk(clk),
	.rst(rst),
	.hostReq(hostReq),
	.hostAck(hostAck),
	.startReq(startReq),
	.startAck(startAck),
	.gntHost(gntHost),
	.gntEng(gntEng),
	.portWe(portWe),
	.engWe(engWe)
);

// File: bench/residuTb.sv
`timescale 1ns/1ns

`include "residu_defs.svh"

module residuTb;

	import residuPkg::*;

	typedef enum int
	{
		patImpulse,
		patSmall,
		patFull,
		patSat,
		patRamp
	} pattern_t;

	typedef struct
	{
		pattern_t kind;
		int coefScale;
	} row_t;

	localparam int NUM_ROWS = 6;
	localparam int NUM_COEF = `ORDER + 1;
	localparam int NUM_X = `ORDER + `FRAME_LEN;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 4000 + 2000;
	localparam longint MAX32 = 64'sd2147483647;
	localparam longint MIN32 = -64'sd2147483648;

	logic clk;
	logic rst;
	logic hostReq;
	logic hostWe;
	addr_t hostAddr;
	sample_t hostWdata;
	logic hostAck;
	sample_t hostRdata;
	logic startReq;
	logic startAck;

	row_t rows [NUM_ROWS];
	sample_t coefs [NUM_COEF];
	// xs[i] holds x[i - ORDER]
	sample_t xs [NUM_X];
	sample_t expY [`FRAME_LEN];
	int sampleErrors;
	int bitErrors;
	logic frameAckSeen;

	residuTop i_residuTop
	(
		.clk(clk),
		.rst(rst),
		.hostReq(hostReq),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostWdata(hostWdata),
		.hostAck(hostAck),
		.hostRdata(hostRdata),
		.startReq(startReq),
		.startAck(startAck)
	);

	initial
	begin
		clk = 1'b0;
	end

	always
	begin
		#20 clk = ~clk;
	end

	// Generous bound, a row needs well under 4000 cycles
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic longint clip32(longint v);
		longint r;
		r = v;
		if (v > MAX32)
		begin
			r = MAX32;
		end
		else if (v < MIN32)
		begin
			r = MIN32;
		end
		return r;
	endfunction

	// Q15 times Q15 into Q31, only -1 times -1 clips
	function automatic longint fracMul(sample_t a, sample_t b);
		return clip32(2 * longint'(a) * longint'(b));
	endfunction

	function automatic sample_t modelOutput(int n);
		acc_t acc;
		longint v;
		acc = '0;
		for (int j = 0; j <= `ORDER; j++)
		begin
			acc = acc_t'(clip32(longint'(acc) + fracMul(coefs[j], xs[n - j + `ORDER])));
		end
		// Scale by eight, then round into the upper half word
		v = clip32(longint'(acc) * 8);
		v = clip32(v + 32768);
		return sample_t'(v >>> 16);
	endfunction

	function automatic sample_t randRange(int scale);
		return sample_t'(int'($urandom % (2 * scale + 1)) - scale);
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic checkSample(string name, sample_t actual, sample_t expected);
		if (actual !== expected)
		begin
			sampleErrors++;
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, name, actual,
				expected);
		end
	endtask

	task automatic checkBit(string name, logic actual, logic expected);
		if (actual !== expected)
		begin
			bitErrors++;
			$display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	////////////////////////////////////////
	// Handshakes
	////////////////////////////////////////

	task automatic hostWrite(addr_t addr, sample_t data);
		@(negedge clk);
		hostWe = 1'b1;
		hostAddr = addr;
		hostWdata = data;
		hostReq = 1'b1;
		@(negedge clk);
		while (!hostAck)
		begin
			@(negedge clk);
		end
		hostReq = 1'b0;
		@(negedge clk);
		while (hostAck)
		begin
			@(negedge clk);
		end
	endtask

	task automatic hostRead(addr_t addr, output sample_t data);
		@(negedge clk);
		hostWe = 1'b0;
		hostAddr = addr;
		hostReq = 1'b1;
		@(negedge clk);
		while (!hostAck)
		begin
			@(negedge clk);
		end
		data = hostRdata;
		hostReq = 1'b0;
		@(negedge clk);
		while (hostAck)
		begin
			@(negedge clk);
		end
	endtask

	task automatic runFrame();
		checkBit("startAck", startAck, 1'b0);
		@(negedge clk);
		startReq = 1'b1;
		@(negedge clk);
		while (!startAck)
		begin
			@(negedge clk);
		end
		frameAckSeen = 1'b1;
		// Ack has to stay up while the request is held
		repeat (2) @(negedge clk);
		checkBit("startAck", startAck, 1'b1);
		startReq = 1'b0;
		@(negedge clk);
		while (startAck)
		begin
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic buildRow(row_t r);
		for (int j = 0; j < NUM_COEF; j++)
		begin
			coefs[j] = (r.kind == patSat) ? 16'sh8000 : randRange(r.coefScale);
		end
		for (int i = 0; i < NUM_X; i++)
		begin
			case (r.kind)
				patImpulse:
					xs[i] = (i == `ORDER) ? 16'sd4096 : 16'sd0;
				patSmall:
					xs[i] = randRange(1024);
				patFull:
					xs[i] = sample_t'($urandom);
				patSat:
					xs[i] = 16'sh8000;
				default:
					xs[i] = sample_t'(i * 1300 - 32000);
			endcase
		end
		for (int n = 0; n < `FRAME_LEN; n++)
		begin
			expY[n] = modelOutput(n);
		end
	endtask

	task automatic applyRow(int idx);
		sample_t got;
		sample_t during;
		buildRow(rows[idx]);
		for (int j = 0; j < NUM_COEF; j++)
		begin
			hostWrite(addr_t'(`COEF_BASE + j), coefs[j]);
		end
		for (int i = 0; i < NUM_X; i++)
		begin
			hostWrite(addr_t'(`X_BASE + i), xs[i]);
		end
		frameAckSeen = 1'b0;
		// Host read of x[5] has to wait for the frame to release the memory
		fork
			runFrame();
			begin
				repeat (5) @(negedge clk);
				hostRead(addr_t'(`X_BASE + `ORDER + 5), during);
				checkBit("startAck seen before hostAck", frameAckSeen, 1'b1);
				checkSample("x[5] read during frame", during, xs[`ORDER + 5]);
			end
		join
		for (int n = 0; n < `FRAME_LEN; n++)
		begin
			hostRead(addr_t'(`Y_BASE + n), got);
			checkSample($sformatf("row %0d y[%0d]", idx, n), got, expY[n]);
		end
		for (int j = 0; j < NUM_COEF; j++)
		begin
			hostRead(addr_t'(`COEF_BASE + j), got);
			checkSample($sformatf("row %0d a[%0d]", idx, j), got, coefs[j]);
		end
		for (int i = 0; i < NUM_X; i++)
		begin
			hostRead(addr_t'(`X_BASE + i), got);
			checkSample($sformatf("row %0d x[%0d]", idx, i - `ORDER), got, xs[i]);
		end
	endtask

	initial
	begin
		sample_t got;
		sample_t scratch [8];
		void'($urandom(78457));
		rst = 1'b1;
		hostReq = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostWdata = '0;
		startReq = 1'b0;
		sampleErrors = 0;
		bitErrors = 0;
		frameAckSeen = 1'b0;

		rows[0] = '{kind: patImpulse, coefScale: 32767};
		rows[1] = '{kind: patSmall, coefScale: 1024};
		rows[2] = '{kind: patFull, coefScale: 32767};
		rows[3] = '{kind: patSat, coefScale: 32768};
		rows[4] = '{kind: patRamp, coefScale: 8192};
		rows[5] = '{kind: patFull, coefScale: 4096};

		repeat (3) @(negedge clk);
		rst = 1'b0;
		checkBit("hostAck", hostAck, 1'b0);
		checkBit("startAck", startAck, 1'b0);

		// Scratch words outside the memory map
		for (int k = 0; k < 8; k++)
		begin
			scratch[k] = sample_t'($urandom);
			hostWrite(addr_t'(200 + k), scratch[k]);
		end
		for (int k = 0; k < 8; k++)
		begin
			hostRead(addr_t'(200 + k), got);
			checkSample($sformatf("scratch[%0d]", k), got, scratch[k]);
		end

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			applyRow(r);
		end

		$display("Errors: %0d sample mismatches, %0d handshake mismatches", sampleErrors,
			bitErrors);
		if (sampleErrors == 0 && bitErrors == 0)
		begin
			$display("** PASS **");
		end
		else
		begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+hw
hw/residuPkg.sv
hw/sampleMem.sv
hw/memArbiter.sv
hw/satMacUnit.sv
hw/residuEngine.sv
hw/hostPort.sv
hw/residuTop.sv
bench/residu_sva.sv
bench/residuTb.sv

// File: Makefile
TOP = residuTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "\*\* FAIL \*\*" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "\*\* PASS \*\*" sim.log; then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
